// File: src/aznable_pkg.sv
package aznable_pkg;

	// CPU bus
	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	// Memory map
	localparam logic [ADDR_W-1:0] IN0_ADDR = 16'h8000;
	localparam logic [ADDR_W-1:0] TIMER_BASE = 16'h80C0;
	localparam logic [ADDR_W-1:0] JOY_BASE = 16'h8100;
	localparam logic [ADDR_W-1:0] PAUSE_ADDR = 16'h8530;
	localparam logic [ADDR_W-1:0] MENU_ADDR = 16'h8531;
	localparam logic [ADDR_W-1:0] VEC_BASE = 16'hC000;

	// 4 KiB of polyline entries
	localparam int VEC_LIST_AW = 12;

	// 6 devices, 32 buttons each
	localparam int JOY_W = 192;

	// Video timing in pixels and lines
	localparam int H_VISIBLE = 320;
	localparam int H_BLANK_END = 384;
	localparam int H_SYNC_START = 336;
	localparam int H_SYNC_END = 368;
	localparam int V_VISIBLE = 240;
	localparam int V_TOTAL = 262;
	localparam int V_SYNC_START = 244;
	localparam int V_SYNC_END = 247;
	localparam int CNT_W = 9;

	// 24 MHz system clock
	localparam int CLK_PER_MS = 24000;

	// Vector engine limits
	localparam int POINTS_MAX = 16;
	localparam int COORD_W = 8;

	// Framebuffer address is {y, x}
	localparam int FB_AW = 16;

endpackage

// File: src/cpu_bus_if.sv
`timescale 1ns/1ns

interface cpu_bus_if;
	import aznable_pkg::*;

	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata;
	logic wr;
	logic [DATA_W-1:0] rdata;

	// Driven from the top level CPU pins
	modport host (
		output addr, wdata, wr,
		input rdata
	);

	modport target (
		input addr, wdata, wr,
		output rdata
	);

endinterface

// File: src/video_if.sv
`timescale 1ns/1ns

interface video_if;
	import aznable_pkg::*;

	logic ce;
	logic [CNT_W-1:0] hcnt;
	logic [CNT_W-1:0] vcnt;
	logic hblank;
	logic vblank;
	logic hsync;
	logic vsync;

	modport source (
		output ce, hcnt, vcnt, hblank, vblank, hsync, vsync
	);

	modport sink (
		input ce, hcnt, vcnt, hblank, vblank, hsync, vsync
	);

endinterface

// File: src/video_timing.sv
`timescale 1ns/1ns

module video_timing #(
	parameter int H_VISIBLE = aznable_pkg::H_VISIBLE,
	parameter int H_BLANK_END = aznable_pkg::H_BLANK_END,
	parameter int H_SYNC_START = aznable_pkg::H_SYNC_START,
	parameter int H_SYNC_END = aznable_pkg::H_SYNC_END,
	parameter int V_VISIBLE = aznable_pkg::V_VISIBLE,
	parameter int V_TOTAL = aznable_pkg::V_TOTAL,
	parameter int V_SYNC_START = aznable_pkg::V_SYNC_START,
	parameter int V_SYNC_END = aznable_pkg::V_SYNC_END
) (
	input logic clk_24,
	input logic arst_n,
	input logic ce_6,
	video_if.source vid
);
	import aznable_pkg::*;

	localparam logic [CNT_W-1:0] H_LAST = CNT_W'(H_BLANK_END - 1);
	localparam logic [CNT_W-1:0] V_LAST = CNT_W'(V_TOTAL - 1);

	always_ff @(posedge clk_24 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			vid.hcnt <= '0;
			vid.vcnt <= '0;
		end
		else if (ce_6)
		begin
			if (vid.hcnt == H_LAST)
			begin
				vid.hcnt <= '0;
				// Line wrap steps the vertical counter
				vid.vcnt <= (vid.vcnt == V_LAST) ? '0 : vid.vcnt + 1'b1;
			end
			else
			begin
				vid.hcnt <= vid.hcnt + 1'b1;
			end
		end
	end

	assign vid.ce = ce_6;

	// Blanking and sync straight from the counters
	assign vid.hblank = vid.hcnt >= CNT_W'(H_VISIBLE);
	assign vid.vblank = vid.vcnt >= CNT_W'(V_VISIBLE);
	assign vid.hsync = (vid.hcnt >= CNT_W'(H_SYNC_START)) && (vid.hcnt < CNT_W'(H_SYNC_END));
	assign vid.vsync = (vid.vcnt >= CNT_W'(V_SYNC_START)) && (vid.vcnt < CNT_W'(V_SYNC_END));

endmodule

// File: src/system_regs.sv
`timescale 1ns/1ns

module system_regs #(
	parameter int CLK_PER_MS = aznable_pkg::CLK_PER_MS
) (
	input logic clk_24,
	input logic arst_n,
	cpu_bus_if.target bus,
	video_if.sink vid,
	input logic [aznable_pkg::JOY_W-1:0] joystick,
	input logic menu,
	input logic pause,
	input logic [aznable_pkg::DATA_W-1:0] vec_rdata,
	output logic vec_we,
	output logic cpu_wait_n
);
	import aznable_pkg::*;

	localparam int TIMER_SPAN = 16;
	localparam int JOY_SPAN = 192;
	localparam int JOY_BYTES = JOY_W / DATA_W;
	localparam int TIMER_W = 16;
	localparam int PRESC_W = $clog2(CLK_PER_MS);

	logic in0_cs;
	logic timer_cs;
	logic joy_cs;
	logic pause_cs;
	logic menu_cs;
	logic vec_cs;
	logic pause_trigger;
	logic menu_trigger;
	logic [PRESC_W-1:0] presc;
	logic [TIMER_W-1:0] ms_count;
	logic [4:0] joy_byte;
	logic [DATA_W-1:0] in0_data;
	logic [DATA_W-1:0] joy_data;
	logic [DATA_W-1:0] timer_data;

	// Address decode
	assign in0_cs = bus.addr == IN0_ADDR;
	assign timer_cs = (bus.addr >= TIMER_BASE) && (bus.addr < TIMER_BASE + ADDR_W'(TIMER_SPAN));
	assign joy_cs = (bus.addr >= JOY_BASE) && (bus.addr < JOY_BASE + ADDR_W'(JOY_SPAN));
	assign pause_cs = bus.addr == PAUSE_ADDR;
	assign menu_cs = bus.addr == MENU_ADDR;
	assign vec_cs = (bus.addr >= VEC_BASE) && (bus.addr < VEC_BASE + ADDR_W'(2 ** VEC_LIST_AW));

	assign vec_we = bus.wr && vec_cs;

	// Either the pause pin or the CPU's own trigger holds the CPU
	assign cpu_wait_n = ~(pause | pause_trigger);

	always_ff @(posedge clk_24 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pause_trigger <= 1'b0;
			menu_trigger <= 1'b0;
		end
		else
		begin
			if (bus.wr && pause_cs) pause_trigger <= 1'b1;
			if (pause) pause_trigger <= 1'b0;
			// Acknowledge by the CPU wins over a held menu input
			if (menu) menu_trigger <= 1'b1;
			if (bus.wr && menu_cs) menu_trigger <= 1'b0;
		end
	end

	// Millisecond timer, cleared by any write in its window
	always_ff @(posedge clk_24 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			presc <= '0;
			ms_count <= '0;
		end
		else if (bus.wr && timer_cs)
		begin
			presc <= '0;
			ms_count <= '0;
		end
		else if (presc == PRESC_W'(CLK_PER_MS - 1))
		begin
			presc <= '0;
			ms_count <= ms_count + 1'b1;
		end
		else
		begin
			presc <= presc + 1'b1;
		end
	end

	assign in0_data = {vid.hsync, vid.vsync, vid.hblank, vid.vblank, 2'b10, menu, 1'b0};
	assign timer_data = bus.addr[0] ? ms_count[15:8] : ms_count[7:0];

	// Bytes 24 to 31 of each 32 byte slot have no joystick behind them
	assign joy_byte = bus.addr[4:0];
	assign joy_data = (joy_byte < 5'(JOY_BYTES)) ? joystick[joy_byte * DATA_W +: DATA_W] : '0;

	always_comb
	begin
		if (in0_cs) bus.rdata = in0_data;
		else if (timer_cs) bus.rdata = timer_data;
		else if (joy_cs) bus.rdata = joy_data;
		else if (menu_cs) bus.rdata = {DATA_W{menu_trigger}};
		else if (vec_cs) bus.rdata = vec_rdata;
		else bus.rdata = '0;
	end

endmodule

// File: src/dual_port_ram.sv
`timescale 1ns/1ns

module dual_port_ram #(
	parameter int AW = 8,
	parameter int DW = 8
) (
	input logic clk_24,
	input logic [AW-1:0] a_addr,
	input logic a_we,
	input logic [DW-1:0] a_wdata,
	output logic [DW-1:0] a_rdata,
	input logic [AW-1:0] b_addr,
	input logic b_we,
	input logic [DW-1:0] b_wdata,
	output logic [DW-1:0] b_rdata
);

	logic [DW-1:0] mem [2 ** AW];

	initial
	begin
		for (int i = 0; i < 2 ** AW; i++)
		begin
			mem[i] = '0;
		end
	end

	// Reads return the old contents on a same-address write
	always @(posedge clk_24)
	begin
		if (a_we) mem[a_addr] <= a_wdata;
		if (b_we) mem[b_addr] <= b_wdata;
		a_rdata <= mem[a_addr];
		b_rdata <= mem[b_addr];
	end

endmodule

// File: src/vector_engine.sv
`timescale 1ns/1ns

module vector_engine (
	input logic clk_24,
	input logic arst_n,
	video_if.sink vid,
	output logic [aznable_pkg::VEC_LIST_AW-1:0] list_addr,
	input logic [aznable_pkg::DATA_W-1:0] list_data,
	output logic [aznable_pkg::FB_AW-1:0] fb_addr,
	output logic fb_we,
	output logic [aznable_pkg::DATA_W-1:0] fb_wdata
);
	import aznable_pkg::*;

	localparam int PT_W = $clog2(POINTS_MAX);
	localparam int ERR_W = COORD_W + 3;
	localparam logic [DATA_W-1:0] PIXEL_ON = {DATA_W{1'b1}};

	localparam logic [3:0] S_RESTART = 4'd0;
	localparam logic [3:0] S_WAIT = 4'd1;
	localparam logic [3:0] S_LEN = 4'd2;
	localparam logic [3:0] S_ATTR = 4'd3;
	localparam logic [3:0] S_PX = 4'd4;
	localparam logic [3:0] S_PY = 4'd5;
	localparam logic [3:0] S_SEG = 4'd6;
	localparam logic [3:0] S_DRAW = 4'd7;
	localparam logic [3:0] S_IDLE = 4'd8;

	logic [3:0] state;
	logic [3:0] state_next;
	logic [PT_W-1:0] idx;
	logic [PT_W-1:0] seg;
	logic [PT_W-1:0] len;
	logic vblank_q;
	logic [COORD_W-1:0] pts_x [POINTS_MAX];
	logic [COORD_W-1:0] pts_y [POINTS_MAX];
	logic [COORD_W-1:0] x0, y0, x1, y1;
	logic [COORD_W-1:0] dx_abs, dy_abs;
	logic [COORD_W-1:0] cur_x, cur_y;
	logic sx_pos, sy_pos;
	logic signed [ERR_W-1:0] dx, dy, err;
	logic signed [ERR_W-1:0] e2, err_next;
	logic step_x, step_y, at_end;

	// Endpoints of the current segment
	assign x0 = pts_x[seg];
	assign y0 = pts_y[seg];
	assign x1 = pts_x[seg + 1'b1];
	assign y1 = pts_y[seg + 1'b1];
	assign dx_abs = (x1 >= x0) ? x1 - x0 : x0 - x1;
	assign dy_abs = (y1 >= y0) ? y1 - y0 : y0 - y1;
	assign at_end = (cur_x == x1) && (cur_y == y1);

	assign fb_wdata = PIXEL_ON;

	// Bresenham step with dy held negative
	always_comb
	begin
		e2 = err <<< 1;
		step_x = e2 >= dy;
		step_y = e2 <= dx;
		err_next = err;
		if (step_x) err_next = err_next + dy;
		if (step_y) err_next = err_next + dx;
	end

	always_ff @(posedge clk_24 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= S_RESTART;
			state_next <= S_LEN;
			list_addr <= '0;
			idx <= '0;
			seg <= '0;
			len <= '0;
			fb_we <= 1'b0;
			vblank_q <= 1'b0;
		end
		else
		begin
			vblank_q <= vid.vblank;
			fb_we <= 1'b0;
			case (state)
				S_RESTART:
				begin
					list_addr <= '0;
					state_next <= S_LEN;
					state <= S_WAIT;
				end
				// One cycle for the list RAM read
				S_WAIT: state <= state_next;
				S_LEN:
				begin
					if (list_data == '0)
					begin
						state <= S_IDLE;
					end
					else
					begin
						len <= list_data[PT_W-1:0];
						idx <= '0;
						list_addr <= list_addr + 1'b1;
						state_next <= S_ATTR;
						state <= S_WAIT;
					end
				end
				S_ATTR:
				begin
					list_addr <= list_addr + 1'b1;
					state_next <= S_PX;
					state <= S_WAIT;
				end
				S_PX:
				begin
					list_addr <= list_addr + 1'b1;
					state_next <= S_PY;
					state <= S_WAIT;
				end
				S_PY:
				begin
					// Address now sits on the next length byte
					list_addr <= list_addr + 1'b1;
					if (idx == len)
					begin
						seg <= '0;
						state <= S_SEG;
					end
					else
					begin
						idx <= idx + 1'b1;
						state_next <= S_PX;
						state <= S_WAIT;
					end
				end
				S_SEG: state <= S_DRAW;
				S_DRAW:
				begin
					fb_we <= 1'b1;
					if (at_end)
					begin
						if (seg == len - 1'b1)
						begin
							state <= S_LEN;
						end
						else
						begin
							seg <= seg + 1'b1;
							state <= S_SEG;
						end
					end
				end
				S_IDLE:
				begin
					if (vid.vblank && !vblank_q) state <= S_RESTART;
				end
				default: state <= S_RESTART;
			endcase
		end
	end

	// Point store and line plotter datapath
	always_ff @(posedge clk_24)
	begin
		case (state)
			S_PX: pts_x[idx] <= list_data;
			S_PY: pts_y[idx] <= list_data;
			S_SEG:
			begin
				cur_x <= x0;
				cur_y <= y0;
				sx_pos <= x1 >= x0;
				sy_pos <= y1 >= y0;
				dx <= $signed(ERR_W'(dx_abs));
				dy <= -$signed(ERR_W'(dy_abs));
				err <= $signed(ERR_W'(dx_abs)) - $signed(ERR_W'(dy_abs));
			end
			S_DRAW:
			begin
				fb_addr <= {cur_y, cur_x};
				if (!at_end)
				begin
					if (step_x) cur_x <= sx_pos ? cur_x + 1'b1 : cur_x - 1'b1;
					if (step_y) cur_y <= sy_pos ? cur_y + 1'b1 : cur_y - 1'b1;
					err <= err_next;
				end
			end
			default: ;
		endcase
	end

endmodule

// File: src/vector_scanout.sv
`timescale 1ns/1ns

module vector_scanout (
	input logic clk_24,
	input logic arst_n,
	video_if.sink vid,
	output logic [aznable_pkg::FB_AW-1:0] fb_addr,
	output logic fb_we,
	output logic [aznable_pkg::DATA_W-1:0] fb_wdata,
	input logic [aznable_pkg::DATA_W-1:0] fb_rdata,
	output logic [aznable_pkg::DATA_W-1:0] vga_r,
	output logic [aznable_pkg::DATA_W-1:0] vga_g,
	output logic [aznable_pkg::DATA_W-1:0] vga_b,
	output logic vga_hblank,
	output logic vga_vblank,
	output logic vga_hsync,
	output logic vga_vsync
);
	import aznable_pkg::*;

	localparam logic [CNT_W-1:0] AREA = CNT_W'(2 ** COORD_W);

	logic [1:0] phase;
	logic in_area;
	logic [DATA_W-1:0] pix_hold;
	logic [DATA_W-1:0] grey;

	assign in_area = (vid.hcnt < AREA) && (vid.vcnt < AREA);
	assign fb_addr = {vid.vcnt[COORD_W-1:0], vid.hcnt[COORD_W-1:0]};

	// Phase 0 addresses the RAM, phase 1 sees the data, phase 2 writes back
	always_ff @(posedge clk_24 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			phase <= '0;
			fb_we <= 1'b0;
			pix_hold <= '0;
			grey <= '0;
			vga_hblank <= 1'b0;
			vga_vblank <= 1'b0;
			vga_hsync <= 1'b0;
			vga_vsync <= 1'b0;
		end
		else
		begin
			fb_we <= 1'b0;
			phase <= vid.ce ? 2'd0 : phase + 2'd1;
			if (phase == 2'd1)
			begin
				pix_hold <= in_area ? fb_rdata : '0;
				fb_we <= in_area;
			end
			// Pixel leaves one pixel period after it was addressed
			if (vid.ce)
			begin
				grey <= (vid.hblank || vid.vblank) ? '0 : pix_hold;
				vga_hblank <= vid.hblank;
				vga_vblank <= vid.vblank;
				vga_hsync <= vid.hsync;
				vga_vsync <= vid.vsync;
			end
		end
	end

	// Fade by one bit per frame
	always_ff @(posedge clk_24)
	begin
		if (phase == 2'd1) fb_wdata <= {fb_rdata[DATA_W-2:0], 1'b0};
	end

	assign vga_r = grey;
	assign vga_g = grey;
	assign vga_b = grey;

endmodule

// File: src/aznable_vector_top.sv
`timescale 1ns/1ns

module aznable_vector_top (
	input logic clk_24,
	input logic arst_n,
	input logic ce_6,
	input logic [aznable_pkg::ADDR_W-1:0] cpu_addr,
	input logic [aznable_pkg::DATA_W-1:0] cpu_dout,
	input logic cpu_wr_n,
	output logic [aznable_pkg::DATA_W-1:0] cpu_din,
	output logic cpu_wait_n,
	input logic pause,
	input logic menu,
	input logic [aznable_pkg::JOY_W-1:0] joystick,
	output logic [aznable_pkg::DATA_W-1:0] vga_r,
	output logic [aznable_pkg::DATA_W-1:0] vga_g,
	output logic [aznable_pkg::DATA_W-1:0] vga_b,
	output logic vga_hs,
	output logic vga_vs,
	output logic vga_hb,
	output logic vga_vb
);
	import aznable_pkg::*;

	cpu_bus_if bus ();
	video_if vid ();

	logic vec_we;
	logic [DATA_W-1:0] vec_rdata;
	logic [VEC_LIST_AW-1:0] list_addr;
	logic [DATA_W-1:0] list_data;
	logic [FB_AW-1:0] draw_fb_addr;
	logic draw_fb_we;
	logic [DATA_W-1:0] draw_fb_wdata;
	logic [FB_AW-1:0] scan_fb_addr;
	logic scan_fb_we;
	logic [DATA_W-1:0] scan_fb_wdata;
	logic [DATA_W-1:0] scan_fb_rdata;

	// CPU pins onto the internal bus
	assign bus.addr = cpu_addr;
	assign bus.wdata = cpu_dout;
	assign bus.wr = ~cpu_wr_n;
	assign cpu_din = bus.rdata;

	video_timing #(
		.H_VISIBLE(H_VISIBLE),
		.H_BLANK_END(H_BLANK_END),
		.H_SYNC_START(H_SYNC_START),
		.H_SYNC_END(H_SYNC_END),
		.V_VISIBLE(V_VISIBLE),
		.V_TOTAL(V_TOTAL),
		.V_SYNC_START(V_SYNC_START),
		.V_SYNC_END(V_SYNC_END)
	) u_timing (
		.clk_24(clk_24),
		.arst_n(arst_n),
		.ce_6(ce_6),
		.vid(vid)
	);

	system_regs #(
		.CLK_PER_MS(CLK_PER_MS)
	) u_regs (
		.clk_24(clk_24),
		.arst_n(arst_n),
		.bus(bus),
		.vid(vid),
		.joystick(joystick),
		.menu(menu),
		.pause(pause),
		.vec_rdata(vec_rdata),
		.vec_we(vec_we),
		.cpu_wait_n(cpu_wait_n)
	);

	// CPU on port A, engine reads on port B
	dual_port_ram #(
		.AW(VEC_LIST_AW),
		.DW(DATA_W)
	) vec_list_ram (
		.clk_24(clk_24),
		.a_addr(cpu_addr[VEC_LIST_AW-1:0]),
		.a_we(vec_we),
		.a_wdata(bus.wdata),
		.a_rdata(vec_rdata),
		.b_addr(list_addr),
		.b_we(1'b0),
		.b_wdata('0),
		.b_rdata(list_data)
	);

	// Engine draws on port A, scanout fades on port B
	dual_port_ram #(
		.AW(FB_AW),
		.DW(DATA_W)
	) framebuffer_ram (
		.clk_24(clk_24),
		.a_addr(draw_fb_addr),
		.a_we(draw_fb_we),
		.a_wdata(draw_fb_wdata),
		.a_rdata(),
		.b_addr(scan_fb_addr),
		.b_we(scan_fb_we),
		.b_wdata(scan_fb_wdata),
		.b_rdata(scan_fb_rdata)
	);

	vector_engine u_engine (
		.clk_24(clk_24),
		.arst_n(arst_n),
		.vid(vid),
		.list_addr(list_addr),
		.list_data(list_data),
		.fb_addr(draw_fb_addr),
		.fb_we(draw_fb_we),
		.fb_wdata(draw_fb_wdata)
	);

	vector_scanout u_scanout (
		.clk_24(clk_24),
		.arst_n(arst_n),
		.vid(vid),
		.fb_addr(scan_fb_addr),
		.fb_we(scan_fb_we),
		.fb_wdata(scan_fb_wdata),
		.fb_rdata(scan_fb_rdata),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b),
		.vga_hblank(vga_hb),
		.vga_vblank(vga_vb),
		.vga_hsync(vga_hs),
		.vga_vsync(vga_vs)
	);

endmodule

// File: test/aznable_assertions.sv
`timescale 1ns/1ns

module aznable_assertions (
	input logic clk_24,
	input logic arst_n,
	input logic pause,
	input logic [aznable_pkg::ADDR_W-1:0] cpu_addr,
	input logic cpu_wr_n,
	input logic cpu_wait_n,
	input logic [aznable_pkg::DATA_W-1:0] vga_r,
	input logic [aznable_pkg::DATA_W-1:0] vga_g,
	input logic [aznable_pkg::DATA_W-1:0] vga_b,
	input logic vga_hb,
	input logic vga_vb,
	input logic draw_fb_we,
	input logic scan_fb_we
);
	import aznable_pkg::*;

	int failures = 0;
	logic pause_wr;

	assign pause_wr = !cpu_wr_n && (cpu_addr == PAUSE_ADDR);

	// A pause write holds the CPU until the pause pin releases it
	wait_low_a: assert property (
		@(posedge clk_24) disable iff (!arst_n)
		((pause_wr || !cpu_wait_n) && !pause) |=> !cpu_wait_n
	)
	else
	begin
		failures++;
		$error("cpu_wait_n high while the pause trigger is set");
	end

	// Black during any blanking
	blank_black_a: assert property (
		@(posedge clk_24) disable iff (!arst_n)
		(vga_hb || vga_vb) |-> (vga_r == '0 && vga_g == '0 && vga_b == '0)
	)
	else
	begin
		failures++;
		$error("RGB output not zero during blanking");
	end

	fb_quiet_in_reset_a: assert property (
		@(posedge clk_24)
		!arst_n |-> (!draw_fb_we && !scan_fb_we)
	)
	else
	begin
		failures++;
		$error("framebuffer write strobe high in reset");
	end

endmodule

bind aznable_vector_top aznable_assertions u_assertions (
	.clk_24(clk_24),
	.arst_n(arst_n),
	.pause(pause),
	.cpu_addr(cpu_addr),
	.cpu_wr_n(cpu_wr_n),
	.cpu_wait_n(cpu_wait_n),
	.vga_r(vga_r),
	.vga_g(vga_g),
	.vga_b(vga_b),
	.vga_hb(vga_hb),
	.vga_vb(vga_vb),
	.draw_fb_we(draw_fb_we),
	.scan_fb_we(scan_fb_we)
);

// File: test/tb_top.sv
`timescale 1ns/1ns

module tb_top;
	import aznable_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int CE_DIV = 4;
	localparam int DRIVE_DELAY = 1;
	localparam int SAMPLE_DELAY = 2;
	localparam int RESET_CYCLES = 5;
	localparam int FB_SIDE = 2 ** COORD_W;
	localparam int JOY_BYTES = JOY_W / DATA_W;
	localparam int TIMER_MS = 3;
	localparam int LIST_WORDS = 16;
	localparam int POINT_COUNT = 3;
	localparam longint FRAME_CLKS = longint'(H_BLANK_END) * longint'(V_TOTAL) * CE_DIV;
	localparam longint WATCHDOG_CLKS = 4 * FRAME_CLKS + TIMER_MS * CLK_PER_MS;
	localparam logic [ADDR_W-1:0] LIST_TEST_BASE = VEC_BASE + 16'h0800;
	localparam logic [ADDR_W-1:0] UNMAPPED_ADDR = 16'h9000;

	logic clk_24;
	logic arst_n;
	logic ce_6;
	logic [1:0] ce_count;
	logic [ADDR_W-1:0] cpu_addr;
	logic [DATA_W-1:0] cpu_dout;
	logic cpu_wr_n;
	logic [DATA_W-1:0] cpu_din;
	logic cpu_wait_n;
	logic pause;
	logic menu;
	logic [JOY_W-1:0] joystick;
	logic [DATA_W-1:0] vga_r;
	logic [DATA_W-1:0] vga_g;
	logic [DATA_W-1:0] vga_b;
	logic vga_hs;
	logic vga_vs;
	logic vga_hb;
	logic vga_vb;

	// Reference pixel set, indexed {y, x}
	bit on_line [FB_SIDE * FB_SIDE];

	aznable_vector_top dut (
		.clk_24(clk_24),
		.arst_n(arst_n),
		.ce_6(ce_6),
		.cpu_addr(cpu_addr),
		.cpu_dout(cpu_dout),
		.cpu_wr_n(cpu_wr_n),
		.cpu_din(cpu_din),
		.cpu_wait_n(cpu_wait_n),
		.pause(pause),
		.menu(menu),
		.joystick(joystick),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b),
		.vga_hs(vga_hs),
		.vga_vs(vga_vs),
		.vga_hb(vga_hb),
		.vga_vb(vga_vb)
	);

	initial
	begin
		clk_24 = 1'b0;
		forever #(CLK_PERIOD / 2) clk_24 = ~clk_24;
	end

	// Pixel enable on every fourth clock
	initial
	begin
		ce_6 = 1'b0;
		ce_count = '0;
		forever
		begin
			@(posedge clk_24);
			#DRIVE_DELAY;
			ce_count = ce_count + 2'd1;
			ce_6 = ce_count == 2'(CE_DIV - 1);
		end
	end

	initial
	begin
		#(WATCHDOG_CLKS * CLK_PERIOD);
		$display("Timeout: the tests did not finish within %0d clocks", WATCHDOG_CLKS);
		$display("Simulation FAILED");
		$fatal(1, "watchdog expired");
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
		begin
			$display("Mismatch on %s: got 0x%0h, expected 0x%0h", name, got, expected);
			$display("Simulation FAILED");
			$fatal(1, "value check failed");
		end
	endtask

	// One write edge per call
	task automatic write_bus(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		@(posedge clk_24);
		#DRIVE_DELAY;
		cpu_addr = addr;
		cpu_dout = data;
		cpu_wr_n = 1'b0;
		@(posedge clk_24);
		#DRIVE_DELAY;
		cpu_wr_n = 1'b1;
	endtask

	// Address held two cycles so list RAM data has arrived
	task automatic read_bus(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
		@(posedge clk_24);
		#DRIVE_DELAY;
		cpu_addr = addr;
		cpu_wr_n = 1'b1;
		@(posedge clk_24);
		@(posedge clk_24);
		#DRIVE_DELAY;
		data = cpu_din;
	endtask

	// Returns between clock edges, just after a pixel enable edge
	task automatic wait_pixel();
		@(posedge clk_24);
		while (!ce_6) @(posedge clk_24);
		#SAMPLE_DELAY;
	endtask

	task automatic wait_vblank_rise();
		wait_pixel();
		while (vga_vb) wait_pixel();
		while (!vga_vb) wait_pixel();
	endtask

	task automatic plot_reference_line(input int x0, input int y0, input int x1, input int y1);
		int dx;
		int dy;
		int sx;
		int sy;
		int err;
		int e2;
		int x;
		int y;
		dx = (x1 > x0) ? x1 - x0 : x0 - x1;
		dy = (y1 > y0) ? y0 - y1 : y1 - y0;
		sx = (x0 < x1) ? 1 : -1;
		sy = (y0 < y1) ? 1 : -1;
		err = dx + dy;
		x = x0;
		y = y0;
		on_line[y * FB_SIDE + x] = 1'b1;
		while (!(x == x1 && y == y1))
		begin
			e2 = 2 * err;
			if (e2 >= dy)
			begin
				err += dy;
				x += sx;
			end
			if (e2 <= dx)
			begin
				err += dx;
				y += sy;
			end
			on_line[y * FB_SIDE + x] = 1'b1;
		end
	endtask

	task automatic status_joystick_readback();
		int offsets [10] = '{0, 5, 23, 24, 31, 32, 63, 100, 150, 191};
		int slot;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] rd;
		logic [DATA_W-1:0] expected;
		@(posedge clk_24);
		#DRIVE_DELAY;
		for (int i = 0; i < JOY_W / 32; i++) joystick[i * 32 +: 32] = $urandom();
		foreach (offsets[k])
		begin
			addr = JOY_BASE + ADDR_W'(offsets[k]);
			read_bus(addr, rd);
			slot = offsets[k] % 32;
			expected = (slot < JOY_BYTES) ? joystick[slot * DATA_W +: DATA_W] : '0;
			check_value($sformatf("cpu_din @0x%04h", addr), 32'(rd), 32'(expected));
		end
		read_bus(IN0_ADDR, rd);
		check_value("cpu_din[3:0] @IN0", 32'(rd[3:0]), 32'({2'b10, menu, 1'b0}));
		read_bus(UNMAPPED_ADDR, rd);
		check_value("cpu_din @unmapped", 32'(rd), 32'(0));
	endtask

	task automatic menu_trigger_cycle();
		logic [DATA_W-1:0] rd;
		@(posedge clk_24);
		#DRIVE_DELAY;
		menu = 1'b1;
		read_bus(IN0_ADDR, rd);
		check_value("cpu_din[3:0] @IN0 menu held", 32'(rd[3:0]), 32'({2'b10, menu, 1'b0}));
		@(posedge clk_24);
		#DRIVE_DELAY;
		menu = 1'b0;
		read_bus(MENU_ADDR, rd);
		check_value("cpu_din @MENU set", 32'(rd), 32'(8'hFF));
		write_bus(MENU_ADDR, 8'h00);
		read_bus(MENU_ADDR, rd);
		check_value("cpu_din @MENU cleared", 32'(rd), 32'(8'h00));
	endtask

	task automatic pause_release();
		write_bus(PAUSE_ADDR, 8'h01);
		check_value("cpu_wait_n after pause write", 32'(cpu_wait_n), 32'(0));
		@(posedge clk_24);
		#DRIVE_DELAY;
		pause = 1'b1;
		#DRIVE_DELAY;
		check_value("cpu_wait_n with pause input", 32'(cpu_wait_n), 32'(0));
		@(posedge clk_24);
		#DRIVE_DELAY;
		pause = 1'b0;
		#DRIVE_DELAY;
		check_value("cpu_wait_n after pause pulse", 32'(cpu_wait_n), 32'(1));
	endtask

	task automatic ms_timer_count();
		logic [DATA_W-1:0] lo;
		logic [DATA_W-1:0] hi;
		write_bus(TIMER_BASE, 8'h00);
		repeat (TIMER_MS * CLK_PER_MS + 10) @(posedge clk_24);
		read_bus(TIMER_BASE, lo);
		read_bus(TIMER_BASE + 16'd1, hi);
		check_value("ms timer {hi, lo}", 32'({hi, lo}), 32'(TIMER_MS));
	endtask

	// Kept clear of the list start so the engine stays idle
	task automatic list_ram_readback();
		logic [ADDR_W-1:0] addrs [LIST_WORDS];
		logic [DATA_W-1:0] data [LIST_WORDS];
		logic [DATA_W-1:0] rd;
		for (int i = 0; i < LIST_WORDS; i++)
		begin
			addrs[i] = LIST_TEST_BASE + ADDR_W'(i * 64) + ADDR_W'($urandom() % 64);
			data[i] = DATA_W'($urandom());
			write_bus(addrs[i], data[i]);
		end
		for (int i = 0; i < LIST_WORDS; i++)
		begin
			read_bus(addrs[i], rd);
			check_value($sformatf("cpu_din @0x%04h", addrs[i]), 32'(rd), 32'(data[i]));
		end
	endtask

	task automatic line_drawing_frame();
		logic [COORD_W-1:0] px [POINT_COUNT] = '{8'd12, 8'd200, 8'd64};
		logic [COORD_W-1:0] py [POINT_COUNT] = '{8'd20, 8'd90, 8'd230};
		logic [DATA_W-1:0] expected;
		string where;
		int x;
		int y;
		int hpos;
		int vline;
		logic hb_prev;
		for (int i = 0; i < FB_SIDE * FB_SIDE; i++) on_line[i] = 1'b0;
		for (int i = 0; i < POINT_COUNT - 1; i++)
			plot_reference_line(px[i], py[i], px[i + 1], py[i + 1]);
		write_bus(VEC_BASE + 16'd1, 8'h5A);
		for (int i = 0; i < POINT_COUNT; i++)
		begin
			write_bus(VEC_BASE + ADDR_W'(2 + 2 * i), px[i]);
			write_bus(VEC_BASE + ADDR_W'(3 + 2 * i), py[i]);
		end
		// Length byte last so a walk never sees a half-written entry
		write_bus(VEC_BASE, 8'(POINT_COUNT - 1));
		wait_vblank_rise();
		wait_vblank_rise();
		// Lines of vertical blanking start where horizontal blanking ends
		vline = V_VISIBLE;
		hb_prev = vga_hb;
		while (vga_vb)
		begin
			if (hb_prev && !vga_hb) vline++;
			hb_prev = vga_hb;
			check_value($sformatf("vga_vs on line %0d", vline), 32'(vga_vs),
				32'(vline >= V_SYNC_START && vline < V_SYNC_END));
			wait_pixel();
		end
		x = 0;
		y = 0;
		hpos = H_VISIBLE;
		while (!vga_vb)
		begin
			check_value("vga_vs in visible frame", 32'(vga_vs), 32'(0));
			if (vga_hb)
			begin
				if (x != 0)
				begin
					check_value($sformatf("visible width of row %0d", y), x, H_VISIBLE);
					y++;
					x = 0;
					hpos = H_VISIBLE;
				end
				check_value($sformatf("vga_hs at column %0d", hpos), 32'(vga_hs),
					32'(hpos >= H_SYNC_START && hpos < H_SYNC_END));
				hpos++;
			end
			else
			begin
				expected = (x < FB_SIDE && on_line[y * FB_SIDE + x]) ? 8'hFF : 8'h00;
				where = $sformatf("(%0d,%0d)", x, y);
				check_value({"vga_r ", where}, 32'(vga_r), 32'(expected));
				check_value({"vga_g ", where}, 32'(vga_g), 32'(expected));
				check_value({"vga_b ", where}, 32'(vga_b), 32'(expected));
				x++;
			end
			wait_pixel();
		end
		check_value("visible height", y, V_VISIBLE);
	endtask

	initial
	begin
		void'($urandom(32'h2b74));
		arst_n = 1'b1;
		cpu_addr = '0;
		cpu_dout = '0;
		cpu_wr_n = 1'b1;
		pause = 1'b0;
		menu = 1'b0;
		joystick = '0;
		#DRIVE_DELAY;
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_24);
		#DRIVE_DELAY;
		arst_n = 1'b1;
		check_value("cpu_wait_n after reset", 32'(cpu_wait_n), 32'(1));

		status_joystick_readback();
		menu_trigger_cycle();
		pause_release();
		ms_timer_count();
		list_ram_readback();
		line_drawing_frame();

		if (dut.u_assertions.failures == 0)
		begin
			$display("Simulation PASSED");
			$finish;
		end
		else
		begin
			$display("%0d assertion failures were seen", dut.u_assertions.failures);
			$display("Simulation FAILED");
			$fatal(1, "assertion failures");
		end
	end

endmodule

// File: flist.f
src/aznable_pkg.sv
src/cpu_bus_if.sv
src/video_if.sv
src/video_timing.sv
src/system_regs.sv
src/dual_port_ram.sv
src/vector_engine.sv
src/vector_scanout.sv
src/aznable_vector_top.sv
test/aznable_assertions.sv
test/tb_top.sv

// File: Makefile
# Verilator build and run for the vector graphics testbench

VERILATOR ?= verilator
TOP ?= tb_top
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
JOBS ?= 0
VFLAGS ?= --binary --timing --assert -j $(JOBS)

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
